// File: source/dcache_pkg.sv
package dcache_pkg;

    // -------------------------------------------------------------------------
    // cache geometry
    // -------------------------------------------------------------------------

    // core side
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned DATA_W = 32;

    // one memory beat carries a whole line
    localparam int unsigned LINE_W = 128;
    localparam int unsigned LINE_BYTES = LINE_W / 8;
    localparam int unsigned SETS = 8;

    // byte address split
    localparam int unsigned OFF_W = $clog2(LINE_BYTES);
    localparam int unsigned IDX_W = $clog2(SETS);
    localparam int unsigned TAG_W = ADDR_W - IDX_W - OFF_W;
    localparam int unsigned LINE_ADDR_W = TAG_W + IDX_W;

    // -------------------------------------------------------------------------
    // access types
    // -------------------------------------------------------------------------

    // top bit set means zero extension on loads
    typedef enum logic [2:0] {
        DT_BYTE   = 3'b000,
        DT_HALF   = 3'b001,
        DT_WORD   = 3'b010,
        DT_BYTE_U = 3'b100,
        DT_HALF_U = 3'b101
    } dmem_dtype_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        dmem_dtype_t dtype;
        logic write;
    } core_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFF_W-1:0] off;
    } addr_fields_t;

    // line address is the byte address without the offset
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic write;
        logic [LINE_W-1:0] wline;
    } mem_cmd_t;

endpackage

// File: source/core_req_port.sv
`timescale 1ns/1ps

module core_req_port (
    input  logic clk,
    input  logic rst,
    input  logic req_i,
    input  dcache_pkg::core_req_t core_req_i,
    input  logic done_i,
    output logic ack_o,
    output logic start_o,
    output dcache_pkg::core_req_t req_q_o,
    output dcache_pkg::addr_fields_t fields_o
);
    import dcache_pkg::*;

    logic req_d;
    logic busy_q;
    logic new_req;

    // a request is new only once the previous handshake has fully closed
    assign new_req = req_d && !busy_q && !ack_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_d <= 1'b0;
            busy_q <= 1'b0;
            start_o <= 1'b0;
            ack_o <= 1'b0;
        end else begin
            req_d <= req_i;
            start_o <= new_req;
            if (new_req) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
            // ack held while the core keeps req high
            if (done_i) begin
                ack_o <= 1'b1;
            end else if (!req_d) begin
                ack_o <= 1'b0;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (new_req) begin
            req_q_o <= core_req_i;
        end
    end

    assign fields_o = addr_fields_t'(req_q_o.addr);

endmodule

// File: source/tag_store.sv
`timescale 1ns/1ps

module tag_store (
    input  logic clk,
    input  logic rst,
    input  logic [dcache_pkg::IDX_W-1:0] idx_i,
    input  logic [dcache_pkg::TAG_W-1:0] tag_i,
    input  logic fill_i,
    input  logic mark_dirty_i,
    output logic hit_o,
    output logic victim_dirty_o,
    output logic [dcache_pkg::TAG_W-1:0] victim_tag_o
);
    import dcache_pkg::*;

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    logic [TAG_W-1:0] tag_q [SETS];

    // ------------------------------------------------------------------------
    // metadata updates
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            // refill brings a clean line
            if (fill_i) begin
                valid_q[idx_i] <= 1'b1;
                dirty_q[idx_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[idx_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[idx_i] <= tag_i;
        end
    end

    // lookup
    assign hit_o = valid_q[idx_i] && (tag_q[idx_i] == tag_i);
    assign victim_dirty_o = valid_q[idx_i] && dirty_q[idx_i];
    assign victim_tag_o = tag_q[idx_i];

endmodule

// File: source/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic clk,
    input  logic [dcache_pkg::IDX_W-1:0] idx_i,
    input  logic [dcache_pkg::LINE_BYTES-1:0] we_i,
    input  logic [dcache_pkg::LINE_W-1:0] wline_i,
    output logic [dcache_pkg::LINE_W-1:0] rline_o
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] lines_q [SETS];

    // ------------------------------------------------------------------------
    // data array
    // ------------------------------------------------------------------------

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (we_i[b]) begin
                lines_q[idx_i][b*8 +: 8] <= wline_i[b*8 +: 8];
            end
        end
    end

    // read is asynchronous, so a write shows up on the next cycle
    assign rline_o = lines_q[idx_i];

endmodule

// File: source/data_align.sv
`timescale 1ns/1ps

module data_align (
    input  dcache_pkg::core_req_t req_i,
    input  logic [dcache_pkg::LINE_W-1:0] rline_i,
    output logic [dcache_pkg::LINE_W-1:0] store_line_o,
    output logic [dcache_pkg::LINE_BYTES-1:0] store_be_o,
    output logic [dcache_pkg::DATA_W-1:0] load_data_o
);
    import dcache_pkg::*;

    logic [OFF_W-1:0] off;
    logic [3:0] be_word;
    logic [LINE_W-1:0] placed;
    logic [DATA_W-1:0] word;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    assign off = req_i.addr[OFF_W-1:0];

    // ------------------------------------------------------------------------
    // store path
    // ------------------------------------------------------------------------

    always_comb begin
        case (req_i.dtype)
            DT_BYTE, DT_BYTE_U: be_word = 4'b0001;
            DT_HALF, DT_HALF_U: be_word = 4'b0011;
            default: be_word = 4'b1111;
        endcase
    end

    assign store_be_o = LINE_BYTES'(be_word) << off;
    assign placed = LINE_W'(req_i.wdata) << {off, 3'b000};

    // merge with the current line, enabled bytes only
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            store_line_o[b*8 +: 8] = store_be_o[b] ? placed[b*8 +: 8] : rline_i[b*8 +: 8];
        end
    end

    // ------------------------------------------------------------------------
    // load path
    // ------------------------------------------------------------------------

    assign word = rline_i[off[3:2]*DATA_W +: DATA_W];
    assign byte_sel = word[off[1:0]*8 +: 8];
    assign half_sel = word[off[1]*16 +: 16];

    always_comb begin
        case (req_i.dtype)
            DT_BYTE: load_data_o = {{24{byte_sel[7]}}, byte_sel};
            DT_BYTE_U: load_data_o = {24'h0, byte_sel};
            DT_HALF: load_data_o = {{16{half_sel[15]}}, half_sel};
            DT_HALF_U: load_data_o = {16'h0, half_sel};
            default: load_data_o = word;
        endcase
    end

endmodule

// File: source/miss_ctrl.sv
`timescale 1ns/1ps

module miss_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  dcache_pkg::core_req_t req_i,
    input  dcache_pkg::addr_fields_t fields_i,
    input  logic hit_i,
    input  logic victim_dirty_i,
    input  logic [dcache_pkg::TAG_W-1:0] victim_tag_i,
    input  logic [dcache_pkg::LINE_W-1:0] rline_i,
    input  logic mem_ack_i,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rline_i,
    input  logic [dcache_pkg::DATA_W-1:0] load_data_i,
    input  logic [dcache_pkg::LINE_W-1:0] store_line_i,
    input  logic [dcache_pkg::LINE_BYTES-1:0] store_be_i,
    output logic mem_req_o,
    output dcache_pkg::mem_cmd_t mem_cmd_o,
    output logic fill_o,
    output logic mark_dirty_o,
    output logic [dcache_pkg::LINE_BYTES-1:0] line_we_o,
    output logic [dcache_pkg::LINE_W-1:0] line_wdata_o,
    output logic done_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT_LOW,
        RF_REQ,
        RF_WAIT_LOW,
        RESPOND
    } state_t;

    state_t state_q;
    state_t state_d;
    logic respond;
    logic refill;

    // a hit is answered straight from LOOKUP, a miss from RESPOND
    assign respond = ((state_q == LOOKUP) && hit_i) || (state_q == RESPOND);
    assign refill = (state_q == RF_REQ) && mem_ack_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start_i) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i) begin
                    state_d = IDLE;
                end else if (victim_dirty_i) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = RF_REQ;
                end
            end
            WB_REQ: if (mem_ack_i) state_d = WB_WAIT_LOW;
            // memory must drop ack before the refill starts
            WB_WAIT_LOW: if (!mem_ack_i) state_d = RF_REQ;
            RF_REQ: if (mem_ack_i) state_d = RF_WAIT_LOW;
            RF_WAIT_LOW: if (!mem_ack_i) state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // memory command, line and metadata updates
    // ------------------------------------------------------------------------

    assign mem_req_o = (state_q == WB_REQ) || (state_q == RF_REQ);

    always_comb begin
        mem_cmd_o.write = (state_q == WB_REQ);
        // victim goes back to its own tag, refill fetches the requested one
        mem_cmd_o.line_addr = mem_cmd_o.write ? {victim_tag_i, fields_i.idx}
                                              : {fields_i.tag, fields_i.idx};
        mem_cmd_o.wline = rline_i;
    end

    assign fill_o = refill;
    assign mark_dirty_o = respond && req_i.write;
    assign line_wdata_o = refill ? mem_rline_i : store_line_i;

    always_comb begin
        if (refill) begin
            line_we_o = '1;
        end else if (respond && req_i.write) begin
            line_we_o = store_be_i;
        end else begin
            line_we_o = '0;
        end
    end

    assign done_o = respond;

    // load result
    always_ff @(posedge clk) begin
        if (respond && !req_i.write) begin
            rdata_o <= load_data_i;
        end
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic clk,
    input  logic rst,
    input  logic req_i,
    input  dcache_pkg::core_req_t core_req_i,
    output logic ack_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic mem_req_o,
    output dcache_pkg::mem_cmd_t mem_cmd_o,
    input  logic mem_ack_i,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rline_i
);
    import dcache_pkg::*;

    core_req_t req_q;
    addr_fields_t fields;
    logic start;
    logic done;
    logic hit;
    logic victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic fill;
    logic mark_dirty;
    logic [LINE_BYTES-1:0] line_we;
    logic [LINE_W-1:0] line_wdata;
    logic [LINE_W-1:0] rline;
    logic [LINE_W-1:0] store_line;
    logic [LINE_BYTES-1:0] store_be;
    logic [DATA_W-1:0] load_data;

    // ------------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------------

    core_req_port u_core_req_port (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .core_req_i (core_req_i),
        .done_i     (done),
        .ack_o      (ack_o),
        .start_o    (start),
        .req_q_o    (req_q),
        .fields_o   (fields)
    );

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------

    tag_store u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .idx_i          (fields.idx),
        .tag_i          (fields.tag),
        .fill_i         (fill),
        .mark_dirty_i   (mark_dirty),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    line_store u_line_store (
        .clk     (clk),
        .idx_i   (fields.idx),
        .we_i    (line_we),
        .wline_i (line_wdata),
        .rline_o (rline)
    );

    // ------------------------------------------------------------------------
    // alignment and control
    // ------------------------------------------------------------------------

    data_align u_data_align (
        .req_i        (req_q),
        .rline_i      (rline),
        .store_line_o (store_line),
        .store_be_o   (store_be),
        .load_data_o  (load_data)
    );

    miss_ctrl u_miss_ctrl (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .req_i          (req_q),
        .fields_i       (fields),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .rline_i        (rline),
        .mem_ack_i      (mem_ack_i),
        .mem_rline_i    (mem_rline_i),
        .load_data_i    (load_data),
        .store_line_i   (store_line),
        .store_be_i     (store_be),
        .mem_req_o      (mem_req_o),
        .mem_cmd_o      (mem_cmd_o),
        .fill_o         (fill),
        .mark_dirty_o   (mark_dirty),
        .line_we_o      (line_we),
        .line_wdata_o   (line_wdata),
        .done_o         (done),
        .rdata_o        (rdata_o)
    );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic clk,
    input  logic mem_req_i,
    input  dcache_pkg::mem_cmd_t mem_cmd_i,
    output logic mem_ack_o,
    output logic [dcache_pkg::LINE_W-1:0] mem_rline_o
);
    import dcache_pkg::*;

    localparam int NUM_LINES = 1 << LINE_ADDR_W;

    logic [LINE_W-1:0] lines [NUM_LINES];
    integer seed;
    int delay;

    // transaction log for the testbench checks
    int rd_count;
    int wr_count;
    int op_seq;
    int last_rd_seq;
    int last_wr_seq;
    logic [LINE_ADDR_W-1:0] last_rd_addr;
    logic [LINE_ADDR_W-1:0] last_wr_addr;
    logic [LINE_W-1:0] last_wr_line;

    initial begin
        seed = 4;
        mem_ack_o = 1'b0;
        mem_rline_o = '0;
        rd_count = 0;
        wr_count = 0;
        op_seq = 0;
        last_rd_seq = 0;
        last_wr_seq = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_line = '0;
        // each word holds its own byte address with A5 in the top byte
        for (int la = 0; la < NUM_LINES; la++) begin
            for (int w = 0; w < 4; w++) begin
                lines[la][w*32 +: 32] = 32'hA500_0000 + 32'(la * 16 + w * 4);
            end
        end
        forever begin
            @(negedge clk);
            if (mem_req_i === 1'b1) begin
                delay = 1 + ($random(seed) & 3);
                repeat (delay - 1) @(negedge clk);
                op_seq = op_seq + 1;
                if (mem_cmd_i.write) begin
                    lines[mem_cmd_i.line_addr] = mem_cmd_i.wline;
                    wr_count = wr_count + 1;
                    last_wr_addr = mem_cmd_i.line_addr;
                    last_wr_line = mem_cmd_i.wline;
                    last_wr_seq = op_seq;
                end else begin
                    mem_rline_o = lines[mem_cmd_i.line_addr];
                    rd_count = rd_count + 1;
                    last_rd_addr = mem_cmd_i.line_addr;
                    last_rd_seq = op_seq;
                end
                mem_ack_o = 1'b1;
                // ack stays up until the cache drops its request
                while (mem_req_i === 1'b1) @(negedge clk);
                mem_ack_o = 1'b0;
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int CYCLES_PER_VEC = 60;

    // one access from the vectors file
    typedef struct packed {
        logic [7:0] op;
        logic [2:0] dtype;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        logic [3:0] rd_n;
        logic [3:0] wr_n;
        logic [3:0] hold;
        logic [LINE_ADDR_W-1:0] wb_addr;
        logic [LINE_W-1:0] wb_line;
    } vector_t;

    logic clk;
    logic rst;
    logic req;
    core_req_t core_req;
    logic ack;
    logic [DATA_W-1:0] rdata;
    logic mem_req;
    mem_cmd_t mem_cmd;
    logic mem_ack;
    logic [LINE_W-1:0] mem_rline;

    vector_t vectors [MAX_VEC];
    int n_vec;
    bit loaded;
    int errors;
    int tests_run;
    int tests_failed;

    dcache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .core_req_i  (core_req),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .mem_req_o   (mem_req),
        .mem_cmd_o   (mem_cmd),
        .mem_ack_i   (mem_ack),
        .mem_rline_i (mem_rline)
    );

    mem_model u_mem (
        .clk         (clk),
        .mem_req_i   (mem_req),
        .mem_cmd_i   (mem_cmd),
        .mem_ack_o   (mem_ack),
        .mem_rline_o (mem_rline)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // checks and reporting
    // --------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "error");
    endtask

    // one four-phase access from the core side
    task automatic run_vector(input int num, input vector_t v);
        int rd_before;
        int wr_before;
        int err_before;
        rd_before = u_mem.rd_count;
        wr_before = u_mem.wr_count;
        err_before = errors;
        @(negedge clk);
        core_req.addr = v.addr;
        core_req.wdata = v.wdata;
        core_req.dtype = dmem_dtype_t'(v.dtype);
        core_req.write = (v.op == "S");
        req = 1'b1;
        while (ack !== 1'b1) @(negedge clk);
        if (v.op == "L") begin
            check_value("rdata_o", 128'(rdata), 128'(v.exp_data));
        end
        check_value("memory reads", 128'(u_mem.rd_count - rd_before), 128'(v.rd_n));
        check_value("memory writes", 128'(u_mem.wr_count - wr_before), 128'(v.wr_n));
        if (u_mem.rd_count != rd_before) begin
            check_value("refill line_addr", 128'(u_mem.last_rd_addr),
                        128'(v.addr[ADDR_W-1:OFF_W]));
        end
        if (v.wr_n != 0) begin
            check_value("write-back line_addr", 128'(u_mem.last_wr_addr), 128'(v.wb_addr));
            check_value("write-back wline", u_mem.last_wr_line, v.wb_line);
            assert (u_mem.last_wr_seq < u_mem.last_rd_seq) else begin
                $display("write-back did not come before the refill read at t=%0t", $time);
                errors++;
            end
        end
        // core holds req high a little longer
        repeat (v.hold) begin
            @(negedge clk);
            check_value("ack_o", 128'(ack), 128'(1'b1));
        end
        req = 1'b0;
        while (ack !== 1'b0) @(negedge clk);
        report_test($sformatf("%0d (%c %h)", num, v.op, v.addr), err_before);
    endtask

    // --------------------------------------------------------------------------
    // main sequence
    // --------------------------------------------------------------------------

    initial begin
        int fd;
        int code;
        int n;
        int err_before;
        string line;
        logic [7:0] op;
        logic [2:0] dt;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        logic [3:0] rd_n;
        logic [3:0] wr_n;
        logic [3:0] hold;
        logic [LINE_ADDR_W-1:0] wb_addr;
        logic [LINE_W-1:0] wb_line;

        rst = 1'b1;
        req = 1'b0;
        core_req = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        n_vec = 0;

        fd = $fopen("tests/dcache_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/dcache_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %d %d %d %h %h", op, dt, addr,
                                wdata, exp_data, rd_n, wr_n, hold, wb_addr, wb_line);
                    if (n == 10 && n_vec < MAX_VEC) begin
                        vectors[n_vec] = {op, dt, addr, wdata, exp_data, rd_n, wr_n,
                                          hold, wb_addr, wb_line};
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vec == 0) begin
            $display("no vectors were read from the vectors file");
            errors++;
        end
        loaded = 1'b1;

        // nothing may move while in reset
        err_before = errors;
        repeat (5) begin
            @(negedge clk);
            check_value("ack_o", 128'(ack), 128'(0));
            check_value("mem_req_o", 128'(mem_req), 128'(0));
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("ack_o", 128'(ack), 128'(0));
            check_value("mem_req_o", 128'(mem_req), 128'(0));
        end
        report_test("reset", err_before);

        for (int i = 0; i < n_vec; i++) begin
            run_vector(i, vectors[i]);
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the number of vectors
    initial begin
        wait (loaded);
        repeat ((n_vec + 1) * CYCLES_PER_VEC + 20) @(posedge clk);
        $display("watchdog expired, the cache stopped answering at t=%0t", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: tests/dcache_vectors.txt
# op dtype addr wdata expected_load mem_reads mem_writes hold_cycles wb_line_addr wb_line
# op L load, S store; dtype 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned
L 2 0100 00000000 A5000100 1 0 0 000 0
L 2 0104 00000000 A5000104 0 0 0 000 0
L 2 010C 00000000 A500010C 0 0 0 000 0
S 0 0101 000000EE 00000000 0 0 0 000 0
L 2 0100 00000000 A500EE00 0 0 0 000 0
S 1 0106 0000BEEF 00000000 0 0 0 000 0
L 2 0104 00000000 BEEF0104 0 0 0 000 0
S 2 0108 12345678 00000000 0 0 0 000 0
L 2 0108 00000000 12345678 0 0 0 000 0
S 0 0213 00000080 00000000 1 0 0 000 0
L 2 0210 00000000 80000210 0 0 0 000 0
L 0 0213 00000000 FFFFFF80 0 0 0 000 0
L 4 0213 00000000 00000080 0 0 0 000 0
L 1 0106 00000000 FFFFBEEF 0 0 0 000 0
L 5 0106 00000000 0000BEEF 0 0 0 000 0
L 0 0101 00000000 FFFFFFEE 0 0 0 000 0
L 1 010E 00000000 FFFFA500 0 0 0 000 0
L 1 0104 00000000 00000104 0 0 0 000 0
L 2 0304 00000000 A5000304 1 1 0 010 A500010C12345678BEEF0104A500EE00
L 2 0108 00000000 12345678 1 0 0 000 0
L 5 0092 00000000 0000A500 1 1 0 021 A500021CA5000218A500021480000210
L 2 0094 00000000 A5000094 0 0 3 000 0
S 2 0098 CAFEF00D 00000000 0 0 2 000 0
L 2 0098 00000000 CAFEF00D 0 0 0 000 0

// File: tb.f
source/dcache_pkg.sv
source/core_req_port.sv
source/tag_store.sv
source/line_store.sv
source/data_align.sv
source/miss_ctrl.sv
source/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_dcache -o sim_tb_dcache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
